/* Makefile */
# Verilator build and run of the conversion unit testbench

VERILATOR ?= verilator
TOP       ?= tb_fp_cvt_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
+incdir+hw
hw/fp_types_pkg.sv
hw/lzc_types_pkg.sv
hw/lzc.sv
hw/fp_cvt.sv
hw/fp_rnd.sv
hw/fp_cvt_regs.sv
hw/fp_cvt_top.sv
testbench/fp_cvt_asserts.sv
testbench/tb_fp_cvt_top.sv

/* hw/fp_cvt.sv */
/*
 * conversion stage 1: operand split, i2f normalize via external lzc,
 * f2i shift, rounding and saturation, stage register
 */
`timescale 1ns/1ps
`include "fp_cvt_params.svh"

module fp_cvt import fp_types_pkg::*, lzc_types_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      start_i,
    input  fp32_t     operand_i,
    input  fcvt_op_e  op_i,
    input  rm_e       rm_i,
    input  lzc_cnt_t  lzc_cnt_i,
    input  logic      lzc_zero_i,
    output lzc_data_t lzc_data_o,
    output logic      s1_valid_o,
    output logic      s1_is_f2i_o,
    output logic      s1_sign_o,
    output fp_exp_t   s1_exp_o,
    output fp_mant_t  s1_mant_o,
    output fp_grs_t   s1_grs_o,
    output rm_e       s1_rm_o,
    output logic      s1_zero_o,
    output int32_t    s1_int_o,
    output fp_flags_t s1_flags_o
);
    localparam fp32_t NAN_PAT = `FP_CANON_NAN;

    logic [7:0]  f_exp;
    logic        f_nan;
    logic        f_inf;
    logic        f_oor;
    logic        f_nv;
    logic        f_nx;
    logic        f_up;
    fp_exp_t     f_e;
    fp_exp_t     f_neg;
    fp_mant_t    f_mant;
    logic [87:0] f_fix;   // 32 integer bits . 56 fraction bits
    logic [32:0] f_rnd;
    fp_grs_t     f_grs;
    int32_t      f_res;
    logic        i_sign;
    int32_t      i_mag;
    int32_t      i_norm;

    always_comb begin
        f_exp  = operand_i[30:23];
        f_nan  = (f_exp == NAN_PAT[30:23]) && (operand_i[22:0] != '0);
        f_inf  = (f_exp == NAN_PAT[30:23]) && (operand_i[22:0] == '0);
        f_e    = fp_exp_t'({2'b00, f_exp}) - fp_exp_t'(`FP_BIAS);
        f_neg  = -f_e;
        f_mant = {f_exp != 8'd0, operand_i[22:0]};
        f_oor  = f_e > 10'sd31;
        if (f_oor) begin
            f_fix = '0;
        end else if (f_e >= 10'sd0) begin
            f_fix = {31'd0, f_mant, 33'd0} << f_e[4:0];
        end else if (f_e < -10'sd31) begin
            f_fix = {31'd0, f_mant, 33'd0} >> 31;  // far below 1, sticky only
        end else begin
            f_fix = {31'd0, f_mant, 33'd0} >> f_neg[4:0];
        end
        f_grs = {f_fix[55], f_fix[54], |f_fix[53:0]};
        f_nx  = |f_grs;
        case (rm_i)
            RTZ:     f_up = 1'b0;
            RDN:     f_up = operand_i[31] & f_nx;
            RUP:     f_up = ~operand_i[31] & f_nx;
            RMM:     f_up = f_grs[2];
            default: f_up = f_grs[2] & (f_fix[56] | (|f_grs[1:0]));
        endcase
        f_rnd = {1'b0, f_fix[87:56]} + 33'(f_up);
        if (op_i == F2I_U) begin
            f_oor = f_oor | (operand_i[31] ? (f_rnd != '0) : f_rnd[32]);
        end else begin
            f_oor = f_oor | (f_rnd > (operand_i[31] ? 33'h0_8000_0000 : 33'h0_7FFF_FFFF));
        end
        f_nv  = f_nan | f_inf | f_oor;
        f_res = operand_i[31] ? -f_rnd[31:0] : f_rnd[31:0];
        if (f_nv) begin
            // NaN goes to the positive limit
            if (op_i == F2I_U) begin
                f_res = (operand_i[31] & ~f_nan) ? 32'h0000_0000 : 32'hFFFF_FFFF;
            end else begin
                f_res = (operand_i[31] & ~f_nan) ? 32'h8000_0000 : 32'h7FFF_FFFF;
            end
        end
    end

    always_comb begin
        i_sign = (op_i == I2F_S) & operand_i[31];
        i_mag  = i_sign ? -operand_i : operand_i;
        i_norm = i_mag << lzc_cnt_i;
    end

    assign lzc_data_o = i_mag;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            s1_valid_o <= 1'b0;
        end else begin
            s1_valid_o <= start_i;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            s1_is_f2i_o <= ~op_i[1];
            s1_sign_o   <= i_sign;
            s1_exp_o    <= fp_exp_t'(31 + `FP_BIAS - int'(lzc_cnt_i));
            s1_mant_o   <= i_norm[31:8];
            s1_grs_o    <= {i_norm[7], i_norm[6], |i_norm[5:0]};
            s1_rm_o     <= rm_i;
            s1_zero_o   <= lzc_zero_i;
            s1_int_o    <= f_res;
            s1_flags_o  <= f_nv ? 5'b10000 : {4'b0000, f_nx};  // nv drops nx
        end
    end

endmodule

/* hw/fp_cvt_params.svh */
/*
 * fixed widths, bias, canonical NaN
 * Wishbone register offsets and control word bit positions
 */
`ifndef FP_CVT_PARAMS_SVH
`define FP_CVT_PARAMS_SVH

`define FP_BIAS        127
`define FP_CANON_NAN   32'h7FC0_0000

`define WB_ADDR_W      4

`define REG_OPERAND    4'h0
`define REG_CTRL       4'h4
`define REG_RESULT     4'h8
`define REG_FLAGS      4'hC    // sticky, write 1 to clear, bit 8 busy

`define CTRL_START_BIT 0
`define CTRL_OP_LSB    1
`define CTRL_OP_MSB    2
`define CTRL_RM_LSB    3
`define CTRL_RM_MSB    5

`endif

/* hw/fp_cvt_regs.sv */
/*
 * Wishbone classic register file with registered ack,
 * launch controller FSM and sticky w1c flag register
 */
`timescale 1ns/1ps
`include "fp_cvt_params.svh"

module fp_cvt_regs import fp_types_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`WB_ADDR_W-1:0] wb_adr_i,
    input  logic [31:0]           wb_dat_i,
    output logic [31:0]           wb_dat_o,
    output logic                  wb_ack_o,
    input  logic                  res_valid_i,
    input  int32_t                result_i,
    input  fp_flags_t             flags_i,
    output logic                  start_o,
    output fp32_t                 operand_o,
    output fcvt_op_e              op_o,
    output rm_e                   rm_o
);
    cvt_state_e state;
    logic       req;
    logic       wr;
    logic       busy;
    int32_t     result_q;
    fp_flags_t  flags_q;
    fp_flags_t  flags_clr;

    assign req       = wb_cyc_i & wb_stb_i & ~wb_ack_o;  // one ack per request
    assign wr        = req & wb_we_i;
    assign busy      = (state != IDLE);
    assign flags_clr = (wr && wb_adr_i == `REG_FLAGS) ? wb_dat_i[4:0] : '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o  <= 1'b0;
            wb_dat_o  <= '0;
            start_o   <= 1'b0;
            operand_o <= '0;
            op_o      <= F2I_S;
            rm_o      <= RNE;
        end else begin
            wb_ack_o <= req;
            start_o  <= 1'b0;
            if (req && !wb_we_i) begin
                case (wb_adr_i)
                    `REG_OPERAND: wb_dat_o <= operand_o;
                    `REG_CTRL:    wb_dat_o <= {26'd0, rm_o, op_o, 1'b0};
                    `REG_RESULT:  wb_dat_o <= result_q;
                    `REG_FLAGS:   wb_dat_o <= {23'd0, busy, 3'd0, flags_q};
                    default:      wb_dat_o <= '0;
                endcase
            end
            if (wr && wb_adr_i == `REG_OPERAND) begin
                operand_o <= wb_dat_i;
            end
            // whole ctrl write dropped while a conversion runs
            if (wr && wb_adr_i == `REG_CTRL && !busy) begin
                op_o    <= fcvt_op_e'(wb_dat_i[`CTRL_OP_MSB:`CTRL_OP_LSB]);
                rm_o    <= rm_e'(wb_dat_i[`CTRL_RM_MSB:`CTRL_RM_LSB]);
                start_o <= wb_dat_i[`CTRL_START_BIT];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state    <= IDLE;
            result_q <= '0;
            flags_q  <= '0;
        end else begin
            case (state)
                IDLE:    if (start_o) state <= BUSY;
                BUSY:    if (res_valid_i) state <= DONE;
                default: state <= IDLE;  // done for one cycle
            endcase
            if (res_valid_i) begin
                result_q <= result_i;
            end
            flags_q <= (flags_q & ~flags_clr) | (res_valid_i ? flags_i : 5'b00000);
        end
    end

endmodule

/* hw/fp_cvt_top.sv */
/*
 * conversion unit top: register block, stage 1, lzc, stage 2
 */
`timescale 1ns/1ps
`include "fp_cvt_params.svh"

module fp_cvt_top import fp_types_pkg::*, lzc_types_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`WB_ADDR_W-1:0] wb_adr_i,
    input  logic [31:0]           wb_dat_i,
    output logic [31:0]           wb_dat_o,
    output logic                  wb_ack_o
);
    logic      cvt_start;
    fp32_t     cvt_operand;
    fcvt_op_e  cvt_op;
    rm_e       cvt_rm;
    lzc_data_t lzc_data;
    lzc_cnt_t  lzc_cnt;
    logic      lzc_zero;
    logic      s1_valid;
    logic      s1_is_f2i;
    logic      s1_sign;
    fp_exp_t   s1_exp;
    fp_mant_t  s1_mant;
    fp_grs_t   s1_grs;
    rm_e       s1_rm;
    logic      s1_zero;
    int32_t    s1_int;
    fp_flags_t s1_flags;
    logic      res_valid;
    int32_t    res_data;
    fp_flags_t res_flags;

    fp_cvt_regs u_regs (
        .clk         (clk),         .arst_n_i   (arst_n_i),
        .wb_cyc_i    (wb_cyc_i),    .wb_stb_i   (wb_stb_i),   .wb_we_i   (wb_we_i),
        .wb_adr_i    (wb_adr_i),    .wb_dat_i   (wb_dat_i),
        .wb_dat_o    (wb_dat_o),    .wb_ack_o   (wb_ack_o),
        .res_valid_i (res_valid),   .result_i   (res_data),   .flags_i   (res_flags),
        .start_o     (cvt_start),   .operand_o  (cvt_operand),
        .op_o        (cvt_op),      .rm_o       (cvt_rm)
    );

    fp_cvt u_cvt (
        .clk         (clk),         .arst_n_i   (arst_n_i),   .start_i   (cvt_start),
        .operand_i   (cvt_operand), .op_i       (cvt_op),     .rm_i      (cvt_rm),
        .lzc_cnt_i   (lzc_cnt),     .lzc_zero_i (lzc_zero),   .lzc_data_o (lzc_data),
        .s1_valid_o  (s1_valid),    .s1_is_f2i_o (s1_is_f2i), .s1_sign_o (s1_sign),
        .s1_exp_o    (s1_exp),      .s1_mant_o  (s1_mant),    .s1_grs_o  (s1_grs),
        .s1_rm_o     (s1_rm),       .s1_zero_o  (s1_zero),
        .s1_int_o    (s1_int),      .s1_flags_o (s1_flags)
    );

    lzc u_lzc (
        .data_i      (lzc_data),    .cnt_o      (lzc_cnt),    .zero_o    (lzc_zero)
    );

    fp_rnd u_rnd (
        .clk         (clk),         .arst_n_i   (arst_n_i),
        .s1_valid_i  (s1_valid),    .s1_is_f2i_i (s1_is_f2i), .s1_sign_i (s1_sign),
        .s1_exp_i    (s1_exp),      .s1_mant_i  (s1_mant),    .s1_grs_i  (s1_grs),
        .s1_rm_i     (s1_rm),       .s1_zero_i  (s1_zero),
        .s1_int_i    (s1_int),      .s1_flags_i (s1_flags),
        .res_valid_o (res_valid),   .result_o   (res_data),   .flags_o   (res_flags)
    );

endmodule

/* hw/fp_rnd.sv */
/*
 * conversion stage 2: i2f rounding, carry renormalize and packing,
 * f2i results forwarded, output register
 */
`timescale 1ns/1ps

module fp_rnd import fp_types_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      s1_valid_i,
    input  logic      s1_is_f2i_i,
    input  logic      s1_sign_i,
    input  fp_exp_t   s1_exp_i,
    input  fp_mant_t  s1_mant_i,
    input  fp_grs_t   s1_grs_i,
    input  rm_e       s1_rm_i,
    input  logic      s1_zero_i,
    input  int32_t    s1_int_i,
    input  fp_flags_t s1_flags_i,
    output logic      res_valid_o,
    output int32_t    result_o,
    output fp_flags_t flags_o
);
    logic        nx;
    logic        up;
    logic [24:0] mant_r;
    fp_exp_t     exp_r;
    fp32_t       res_fp;

    always_comb begin
        nx = |s1_grs_i;
        case (s1_rm_i)
            RTZ:     up = 1'b0;
            RDN:     up = s1_sign_i & nx;
            RUP:     up = ~s1_sign_i & nx;
            RMM:     up = s1_grs_i[2];
            default: up = s1_grs_i[2] & (s1_mant_i[0] | (|s1_grs_i[1:0]));  // ties to even
        endcase
        mant_r = {1'b0, s1_mant_i} + 25'(up);
        exp_r  = s1_exp_i;
        if (mant_r[24]) begin
            mant_r = mant_r >> 1;  // 1.111.. rounded up to 10.000..
            exp_r  = s1_exp_i + 10'sd1;
        end
        res_fp = s1_zero_i ? 32'h0000_0000 : {s1_sign_i, exp_r[7:0], mant_r[22:0]};
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= s1_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid_i) begin
            result_o <= s1_is_f2i_i ? s1_int_i : res_fp;
            flags_o  <= s1_is_f2i_i ? s1_flags_i : {4'b0000, nx};
        end
    end

endmodule

/* hw/fp_types_pkg.sv */
/*
 * binary32 and int32 word types, working exponent, mantissa, grs, flags
 * enums for conversion op, rounding mode and controller state
 */
package fp_types_pkg;

    typedef logic [31:0]        fp32_t;
    typedef logic [31:0]        int32_t;
    typedef logic signed [9:0]  fp_exp_t;   // headroom for under/overflow
    typedef logic [23:0]        fp_mant_t;  // hidden bit included
    typedef logic [2:0]         fp_grs_t;
    typedef logic [4:0]         fp_flags_t; // nv dz of uf nx

    typedef enum logic [1:0] {
        F2I_S = 2'd0,
        F2I_U = 2'd1,
        I2F_S = 2'd2,
        I2F_U = 2'd3
    } fcvt_op_e;

    // 5..7 reserved, treated as rne
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } rm_e;

    typedef enum logic [1:0] {IDLE, BUSY, DONE} cvt_state_e;

endpackage

/* hw/lzc.sv */
/*
 * 32-bit leading-zero counter, log-depth tree of paired counts
 */
`timescale 1ns/1ps

module lzc import lzc_types_pkg::*; (
    input  lzc_data_t data_i,
    output lzc_cnt_t  cnt_o,
    output logic      zero_o
);
    lzc_cnt_t cnt [6][32];
    logic     vld [6][32];

    always_comb begin
        for (int k = 0; k < 6; k++) begin
            for (int j = 0; j < 32; j++) begin
                cnt[k][j] = '0;
                vld[k][j] = 1'b0;
            end
        end
        for (int i = 0; i < 32; i++) begin
            vld[0][i] = data_i[i];
        end
        // upper half wins if it has a one, else lower count plus half width
        for (int k = 1; k < 6; k++) begin
            for (int j = 0; j < (32 >> k); j++) begin
                vld[k][j] = vld[k-1][2*j+1] | vld[k-1][2*j];
                cnt[k][j] = vld[k-1][2*j+1] ? cnt[k-1][2*j+1]
                                            : (cnt[k-1][2*j] | lzc_cnt_t'(1 << (k - 1)));
            end
        end
    end

    assign cnt_o  = cnt[5][0];
    assign zero_o = ~vld[5][0];

endmodule

/* hw/lzc_types_pkg.sv */
/*
 * leading-zero counter input and count types
 */
package lzc_types_pkg;

    typedef logic [31:0] lzc_data_t;
    typedef logic [4:0]  lzc_cnt_t;  // all-zero input flagged separately

endpackage

/* testbench/fp_cvt_asserts.sv */
/*
 * concurrent checks on Wishbone ack, pipeline latency,
 * launch only when idle, known result data
 */
`timescale 1ns/1ps

module fp_cvt_asserts (
    input logic        clk,
    input logic        arst_n_i,
    input logic        wb_cyc_i,
    input logic        wb_stb_i,
    input logic        wb_ack_o,
    input logic        cvt_start,
    input logic        busy,
    input logic        res_valid,
    input logic [31:0] res_data
);
    int n_fail = 0;  // assertion failures so far

    a_ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_ack_o |=> !wb_ack_o) else begin
        $error("ack held longer than one cycle");
        n_fail++;
    end

    a_ack_after_stb: assert property (@(posedge clk) disable iff (!arst_n_i)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i)) else begin
        $error("ack without request");
        n_fail++;
    end

    a_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        cvt_start |-> ##2 res_valid) else begin
        $error("res_valid not 2 cycles after start");
        n_fail++;
    end

    a_no_stray_valid: assert property (@(posedge clk) disable iff (!arst_n_i)
        res_valid |-> $past(cvt_start, 2)) else begin
        $error("res_valid without start");
        n_fail++;
    end

    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
        cvt_start |-> !busy) else begin
        $error("start pulsed while busy");
        n_fail++;
    end

    a_result_known: assert property (@(posedge clk) disable iff (!arst_n_i)
        res_valid |-> !$isunknown(res_data)) else begin
        $error("result has X when valid");
        n_fail++;
    end

endmodule

bind fp_cvt_top fp_cvt_asserts u_asserts (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_ack_o  (wb_ack_o),
    .cvt_start (cvt_start),
    .busy      (u_regs.busy),
    .res_valid (res_valid),
    .res_data  (res_data)
);

/* testbench/tb_fp_cvt_top.sv */
/*
 * testbench for the conversion unit: clock, reset, Wishbone tasks,
 * LFSR stimulus, integer reference model, per-test report, watchdog
 */
`timescale 1ns/1ps
`include "fp_cvt_params.svh"

module tb_fp_cvt_top;
    localparam int NCONV   = 110;
    localparam int TIMEOUT = NCONV * 60 * 10 + 2000;

    logic        clk;
    logic        arst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [3:0]  wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    int          tests;

    fp_cvt_top DUT (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // galois step
        end
        return v;
    endfunction

    // procedural errors plus bound assertion failures
    function automatic int error_count();
        return errors + DUT.u_asserts.n_fail;
    endfunction

    function automatic logic round_up(input logic [2:0] rm, input logic s, input logic lsb,
                                      input logic [63:0] rem, input logic [63:0] half);
        case (rm)
            3'd1:    return 1'b0;
            3'd2:    return s && rem != 0;
            3'd3:    return !s && rem != 0;
            3'd4:    return rem >= half;
            default: return rem > half || (rem == half && lsb);  // rne, also 5..7
        endcase
    endfunction

    // {flags, result}
    function automatic logic [36:0] ref_i2f(input logic sgn, input logic [2:0] rm,
                                            input logic [31:0] x);
        logic        s;
        logic [63:0] mag;
        logic [63:0] kept;
        logic [63:0] rem;
        logic [63:0] half;
        int          p;
        int          e;
        s    = sgn & x[31];
        mag  = s ? 64'h1_0000_0000 - x : {32'd0, x};
        p    = 0;
        rem  = 0;
        half = 1;
        if (mag == 0) return '0;
        for (int i = 0; i < 33; i++) if (mag[i]) p = i;
        e = p + 127;
        if (p <= 23) begin
            kept = mag << (23 - p);
        end else begin
            kept = mag >> (p - 23);
            rem  = mag & ((64'd1 << (p - 23)) - 1);
            half = 64'd1 << (p - 24);
        end
        kept = kept + round_up(rm, s, kept[0], rem, half);
        if (kept == 64'd1 << 24) begin
            kept = kept >> 1;
            e    = e + 1;
        end
        return {4'b0000, rem != 0, s, e[7:0], kept[22:0]};
    endfunction

    function automatic logic [36:0] ref_f2i(input logic uns, input logic [2:0] rm,
                                            input logic [31:0] x);
        logic        s;
        logic        nan;
        logic        oor;
        logic [63:0] mant;
        logic [63:0] ip;
        logic [63:0] rem;
        logic [63:0] half;
        int          e;
        int          sh;
        s    = x[31];
        e    = x[30:23];
        nan  = e == 255 && x[22:0] != 0;
        mant = {40'd0, e != 0, x[22:0]};
        oor  = e > 158;  // |x| >= 2^32, also inf and NaN
        rem  = 0;
        half = 1;
        if (e >= 150) begin
            ip = oor ? 64'd0 : mant << (e - 150);
        end else begin
            sh   = (150 - e > 40) ? 40 : 150 - e;
            ip   = mant >> sh;
            rem  = mant & ((64'd1 << sh) - 1);
            half = 64'd1 << (sh - 1);
        end
        ip = ip + round_up(rm, s, ip[0], rem, half);
        if (uns) oor = oor || (s ? ip != 0 : ip > 64'hFFFF_FFFF);
        else     oor = oor || ip > (s ? 64'h8000_0000 : 64'h7FFF_FFFF);
        if (nan || oor) begin
            if (uns) return {5'b10000, (s && !nan) ? 32'h0000_0000 : 32'hFFFF_FFFF};
            else     return {5'b10000, (s && !nan) ? 32'h8000_0000 : 32'h7FFF_FFFF};
        end
        return {4'b0000, rem != 0, s ? -ip[31:0] : ip[31:0]};
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("error %0t ns %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // hold keeps cyc and stb high into the next request
    task automatic wb_xfer(input logic we, input logic [3:0] adr, input logic [31:0] dat,
                           input logic hold, output logic [31:0] rdat);
        int n;
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_ack_o && n < 20);
        if (!wb_ack_o) begin
            $display("bus request at address %h got no ack", adr);
            errors++;
        end
        rdat = wb_dat_o;
        if (!hold) begin
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
            wb_we_i  = 1'b0;
        end
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
        logic [31:0] dummy;
        wb_xfer(1'b1, adr, dat, 1'b0, dummy);
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
        wb_xfer(1'b0, adr, 32'd0, 1'b0, dat);
    endtask

    // poll busy in the flag register until the conversion completes
    task automatic wait_done(input logic need_busy);
        logic [31:0] f;
        logic        seen;
        int          n;
        seen = 1'b0;
        n    = 0;
        do begin
            wb_read(`REG_FLAGS, f);
            seen = seen | f[8];
            n++;
        end while ((f[8] || (need_busy && !seen)) && n < 20);
        if (n >= 20) begin
            $display("conversion did not complete, busy stuck");
            errors++;
        end
    endtask

    task automatic do_cvt(input logic [1:0] op, input logic [2:0] rm, input logic [31:0] x);
        logic [31:0] r;
        logic [31:0] f;
        logic [36:0] exp;
        exp = op[1] ? ref_i2f(op == 2'd2, rm, x) : ref_f2i(op == 2'd1, rm, x);
        wb_write(`REG_OPERAND, x);
        wb_write(`REG_FLAGS, 32'h1F);
        wb_write(`REG_CTRL, {26'd0, rm, op, 1'b1});
        wait_done(1'b1);
        wb_read(`REG_RESULT, r);
        wb_read(`REG_FLAGS, f);
        check("result", exp[31:0], r);
        check("flags", {27'd0, exp[36:32]}, {27'd0, f[4:0]});
        check("busy", 32'd0, {31'd0, f[8]});
    endtask

    task automatic test_end(input string name, input int err0);
        tests++;
        $display("test %0d %s: %s", tests, name, (error_count() == err0) ? "ok" : "failed");
    endtask

    initial begin
        logic [31:0] r;
        int          err0;
        clk      = 1'b0;
        arst_n_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        lfsr     = 32'hb7e7_4fab;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        repeat (2) @(posedge clk);
        #1;
        arst_n_i = 1'b1;

        err0 = error_count();
        do_cvt(2'd2, 3'd0, 32'd0);
        do_cvt(2'd2, 3'd0, 32'd1);
        do_cvt(2'd2, 3'd0, 32'hFFFF_FFFF);
        do_cvt(2'd3, 3'd0, 32'h0100_0000);
        do_cvt(2'd2, 3'd0, 32'h8000_0000);
        test_end("i2f exact", err0);

        err0 = error_count();
        for (int m = 0; m < 5; m++) do_cvt(2'd3, 3'(m), 32'h0100_0001);
        for (int i = 0; i < 40; i++) do_cvt(2'd2 + 2'(rand_bits(1)), rand_bits(3), rand_bits(32));
        test_end("i2f rounding", err0);

        err0 = error_count();
        for (int i = 0; i < 40; i++) begin
            // sign, biased exponent 100..157, fraction
            r = {1'(rand_bits(1)), 8'(100 + rand_bits(6) % 58), 23'(rand_bits(23))};
            do_cvt(2'(rand_bits(1)), rand_bits(3), r);
        end
        test_end("f2i rounding", err0);

        err0 = error_count();
        do_cvt(2'd0, 3'd0, 32'h7FC0_0000);
        do_cvt(2'd1, 3'd0, 32'h7F80_0001);
        do_cvt(2'd0, 3'd0, 32'h7F80_0000);
        do_cvt(2'd0, 3'd0, 32'hFF80_0000);
        do_cvt(2'd1, 3'd0, 32'h4F80_0000);
        do_cvt(2'd0, 3'd0, 32'h4F00_0000);
        do_cvt(2'd1, 3'd1, 32'hBFC0_0000);
        do_cvt(2'd1, 3'd0, 32'hBE80_0000);
        test_end("f2i saturation", err0);

        err0 = error_count();
        wb_write(`REG_FLAGS, 32'h1F);
        wb_write(`REG_OPERAND, 32'h0100_0001);
        wb_write(`REG_CTRL, {26'd0, 3'd1, 2'd3, 1'b1});
        wait_done(1'b1);
        wb_write(`REG_OPERAND, 32'd5);
        wb_write(`REG_CTRL, {26'd0, 3'd0, 2'd3, 1'b1});
        wait_done(1'b1);
        wb_read(`REG_FLAGS, r);
        check("flags sticky", 32'h01, r);
        wb_write(`REG_FLAGS, 32'h1E);
        wb_read(`REG_FLAGS, r);
        check("flags kept", 32'h01, r);
        wb_write(`REG_FLAGS, 32'h01);
        wb_read(`REG_FLAGS, r);
        check("flags cleared", 32'h00, r);
        // second start lands while busy and must be dropped
        wb_write(`REG_OPERAND, 32'h3FC0_0000);
        wb_write(`REG_CTRL, {26'd0, 3'd1, 2'd0, 1'b1});
        wb_write(`REG_CTRL, {26'd0, 3'd3, 2'd3, 1'b1});
        wait_done(1'b0);
        // back-to-back reads with stb held between them
        wb_xfer(1'b0, `REG_RESULT, 32'd0, 1'b1, r);
        check("result", 32'd1, r);
        wb_xfer(1'b0, `REG_CTRL, 32'd0, 1'b1, r);
        check("ctrl", {26'd0, 3'd1, 2'd0, 1'b0}, r);
        wb_read(`REG_FLAGS, r);
        check("flags", 32'h01, r);
        test_end("sticky flags and busy", err0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, error_count());
        if (error_count() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
